//--- sources.f
hw/rvc_pkg.sv
hw/rvc_classify.sv
hw/rvc_expand.sv
hw/rvc_decoder_top.sv
bench/rvc_checker.sv
bench/rvc_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
RUNFLAGS := +verilator+error+limit+100
TOP      := rvc_tb
FILELIST := sources.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- bench/rvc_tb.sv
`timescale 1ns/1ps

module rvc_tb;

  import rvc_pkg::*;

  localparam int unsigned SEED = 32'hcfd3_6b2e;
  // all tests take roughly 400 cycles and the limit is five times that
  localparam int unsigned EST_CYCLES     = 400;
  localparam int unsigned TIMEOUT_CYCLES = 5 * EST_CYCLES;

  // one driven word and what must come out for it
  typedef struct packed {
    logic [ILEN-1:0] word;
    logic [ILEN-1:0] exp;
    logic            c;
    logic            ill;
    int unsigned     cyc;
  } item_t;

  logic            clk_i = 1'b0;
  logic            rst_n_i;
  logic            valid_i;
  logic [ILEN-1:0] instr_i;
  logic [ILEN-1:0] instr_o;
  logic            is_compressed_o;
  logic            illegal_instr_o;
  logic            valid_o;

  // scoreboard where the driver appends and the monitor walks head forward
  item_t       pending[$];
  item_t       pool[$];
  int          head = 0;
  int unsigned cycle = 0;
  int          errors = 0;
  int          checks = 0;

  rvc_decoder_top dut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .valid_i         (valid_i),
    .instr_i         (instr_i),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_instr_o),
    .valid_o         (valid_o)
  );

  bind rvc_decoder_top rvc_checker u_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (valid_i),
    .out_valid_i  (valid_o),
    .compressed_i (is_compressed_o),
    .illegal_i    (illegal_instr_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle == TIMEOUT_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output monitor on the falling edge where outputs are stable
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : monitor
    item_t e;
    if (rst_n_i) begin
      if (valid_o) begin
        if (head >= pending.size()) begin
          $display("valid_o went high at %0d ns with no word outstanding", $time);
          errors++;
        end else begin
          e = pending[head];
          head++;
          checks++;
          // result is due exactly two edges after the sampling edge
          if (cycle != e.cyc + 2) begin
            $display("ERROR at %0d ns: word %08h driven in cycle %0d came out in cycle %0d",
                     $time, e.word, e.cyc, cycle);
            errors++;
          end
          if (instr_o !== e.exp || is_compressed_o !== e.c || illegal_instr_o !== e.ill) begin
            $display("ERROR at %0d ns: word %08h gave %08h c=%b ill=%b, expected %08h c=%b ill=%b",
                     $time, e.word, instr_o, is_compressed_o, illegal_instr_o,
                     e.exp, e.c, e.ill);
            errors++;
          end
        end
      end else if (head < pending.size() && cycle >= pending[head].cyc + 2) begin
        $display("no result came out for word %08h driven in cycle %0d",
                 pending[head].word, pending[head].cyc);
        errors++;
        head++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // driver helpers
  ////////////////////////////////////////////////////////////////////////////

  // drives one word for one cycle right after a falling edge
  task automatic send_word(input logic [ILEN-1:0] word, input logic [ILEN-1:0] exp,
                           input logic c, input logic ill);
    item_t it;
    it.word = word;
    it.exp  = exp;
    it.c    = c;
    it.ill  = ill;
    it.cyc  = cycle;
    pending.push_back(it);
    pool.push_back(it);
    valid_i = 1'b1;
    instr_i = word;
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  // random upper half that the expansion must ignore
  task automatic send_compressed(input logic [15:0] half, input logic [ILEN-1:0] exp);
    logic [ILEN-1:0] word;
    word       = $urandom();
    word[15:0] = half;
    send_word(word, exp, 1'b1, 1'b0);
  endtask

  task automatic send_illegal(input logic [15:0] half);
    logic [ILEN-1:0] word;
    word       = $urandom();
    word[15:0] = half;
    send_word(word, '0, 1'b1, 1'b1);
  endtask

  task automatic report_result(input string name, input int err0);
    while (head < pending.size()) @(negedge clk_i);
    if (errors == err0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic passthrough_words();
    int              err0;
    logic [ILEN-1:0] w;
    err0 = errors;
    for (int i = 0; i < 200; i++) begin
      w      = $urandom();
      w[1:0] = 2'b11;
      send_word(w, w, 1'b0, 1'b0);
    end
    report_result("uncompressed pass-through", err0);
  endtask

  // c.addi4spn, c.lw, c.sw, c.lwsp, c.swsp
  task automatic memory_forms();
    int err0;
    err0 = errors;
    send_compressed(16'h0800, 32'h0101_0413);
    send_compressed(16'h1ffc, 32'h3fc1_0793);
    send_compressed(16'h4144, 32'h0045_2483);
    send_compressed(16'h5c7c, 32'h07c4_2783);
    send_compressed(16'hc60c, 32'h00b6_2423);
    send_compressed(16'hc0a0, 32'h0484_a023);
    send_compressed(16'h42a2, 32'h0081_2283);
    send_compressed(16'h5ffe, 32'h0fc1_2f83);
    send_compressed(16'hc206, 32'h0011_2223);
    send_compressed(16'hc5d2, 32'h0d41_2423);
    report_result("memory and stack forms", err0);
  endtask

  task automatic c1_arith_jumps();
    int err0;
    err0 = errors;
    send_compressed(16'h1575, 32'hffd5_0513);
    // c.nop hint
    send_compressed(16'h0001, 32'h0000_0013);
    send_compressed(16'h461d, 32'h0070_0613);
    send_compressed(16'h7185, 32'hfffe_11b7);
    send_compressed(16'h6105, 32'h0201_0113);
    send_compressed(16'h7139, 32'hfc01_0113);
    send_compressed(16'h8011, 32'h0044_5413);
    send_compressed(16'h86fd, 32'h41f6_d693);
    send_compressed(16'h9b7d, 32'hfff7_7713);
    send_compressed(16'h8c05, 32'h4094_0433);
    send_compressed(16'h8d2d, 32'h00b5_4533);
    send_compressed(16'h8e55, 32'h00d6_6633);
    send_compressed(16'h8ff9, 32'h00e7_f7b3);
    send_compressed(16'ha021, 32'h0080_006f);
    send_compressed(16'hb001, 32'h801f_f06f);
    send_compressed(16'h3ffd, 32'hffff_f0ef);
    send_compressed(16'hc801, 32'h0004_0863);
    send_compressed(16'hfcf5, 32'hfe04_9ee3);
    report_result("quadrant 1 arithmetic and control", err0);
  endtask

  task automatic c2_register_forms();
    int err0;
    err0 = errors;
    send_compressed(16'h038e, 32'h0033_9393);
    send_compressed(16'h8082, 32'h0000_8067);
    send_compressed(16'h9302, 32'h0003_00e7);
    send_compressed(16'h852e, 32'h00b0_0533);
    send_compressed(16'h929a, 32'h0062_82b3);
    // ebreak
    send_compressed(16'h9002, 32'h0010_0073);
    report_result("quadrant 2 register forms", err0);
  endtask

  task automatic illegal_encodings();
    int err0;
    err0 = errors;
    // zero addi4spn and the reserved q0 slot
    send_illegal(16'h0000);
    send_illegal(16'h001c);
    send_illegal(16'h8000);
    // fp loads and stores in q0 then q2
    send_illegal(16'h2144);
    send_illegal(16'h6144);
    send_illegal(16'ha60c);
    send_illegal(16'he60c);
    send_illegal(16'h22a2);
    send_illegal(16'h62a2);
    send_illegal(16'ha206);
    send_illegal(16'he206);
    // zero-immediate addi16sp and lui
    send_illegal(16'h6101);
    send_illegal(16'h6181);
    // shamt[5] set
    send_illegal(16'h9011);
    send_illegal(16'h96fd);
    send_illegal(16'h138e);
    // c.subw and c.addw
    send_illegal(16'h9c05);
    send_illegal(16'h9d2d);
    // lwsp into x0 and jr through x0
    send_illegal(16'h4022);
    send_illegal(16'h8002);
    report_result("illegal encodings", err0);
  endtask

  task automatic back_to_back_stream();
    int    err0;
    int    idx;
    item_t it;
    err0 = errors;
    for (int i = 0; i < 32; i++) begin
      // two idle cycles in the middle of the burst
      if (i == 20) begin
        repeat (2) @(negedge clk_i);
      end
      idx = $urandom_range(pool.size() - 1);
      it  = pool[idx];
      send_word(it.word, it.exp, it.c, it.ill);
    end
    report_result("back-to-back stream", err0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_n_i = 1'b0;
    // strobe held high through reset while nothing may come out
    valid_i = 1'b1;
    instr_i = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    valid_i = 1'b0;

    passthrough_words();
    memory_forms();
    c1_arith_jumps();
    c2_register_forms();
    illegal_encodings();
    back_to_back_stream();

    $display("%0d results checked, %0d errors, %0d assertion failures",
             checks, errors, dut.u_checker.assert_fails);
    if (errors == 0 && dut.u_checker.assert_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- bench/rvc_checker.sv
`timescale 1ns/1ps

module rvc_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic in_valid_i,
  input logic out_valid_i,
  input logic compressed_i,
  input logic illegal_i
);

  // failed assertions so far
  int unsigned assert_fails = 0;

  // two register stages sit between the input and output strobes
  latency_two: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i, 2) |-> (out_valid_i == $past(in_valid_i, 2))
  ) else begin
    $error("valid_o does not follow valid_i by two cycles");
    assert_fails++;
  end

  // only the strobes are reset
  quiet_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |=> !out_valid_i
  ) else begin
    $error("valid_o high while reset is asserted");
    assert_fails++;
  end

  // an illegal word is always a 16-bit one
  illegal_is_compressed: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_i && illegal_i) |-> compressed_i
  ) else begin
    $error("illegal_instr_o high without is_compressed_o");
    assert_fails++;
  end

endmodule

//--- hw/rvc_decoder_top.sv
`timescale 1ns/1ps

module rvc_decoder_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic [rvc_pkg::ILEN-1:0] instr_i,
  output logic [rvc_pkg::ILEN-1:0] instr_o,
  output logic                     is_compressed_o,
  output logic                     illegal_instr_o,
  output logic                     valid_o
);

  import rvc_pkg::*;

  // stage 1 to stage 2
  logic            s1_valid;
  logic [ILEN-1:0] s1_instr;
  c_op_e           s1_op;

  // classify the raw word
  rvc_classify u_classify (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .instr_i (instr_i),
    .valid_o (s1_valid),
    .instr_o (s1_instr),
    .op_o    (s1_op)
  );

  // build the 32-bit word and flags
  rvc_expand u_expand (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .valid_i         (s1_valid),
    .instr_i         (s1_instr),
    .op_i            (s1_op),
    .valid_o         (valid_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_instr_o),
    .instr_o         (instr_o)
  );

endmodule

//--- hw/rvc_expand.sv
`timescale 1ns/1ps

module rvc_expand (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic [rvc_pkg::ILEN-1:0] instr_i,
  input  rvc_pkg::c_op_e           op_i,
  output logic                     valid_o,
  output logic                     is_compressed_o,
  output logic                     illegal_instr_o,
  output logic [rvc_pkg::ILEN-1:0] instr_o
);

  import rvc_pkg::*;

  // compressed half of the word
  logic [15:0] c;

  // full register fields
  reg_addr_t rd;
  reg_addr_t rs2;
  // prime fields select x8 to x15
  reg_addr_t rs1_p;
  reg_addr_t rs2_p;
  // link register of the jal pair
  reg_addr_t jal_rd;

  logic [ILEN-1:0] instr_d;
  logic            is_compressed_d;
  logic            illegal_d;

  logic            valid_q;
  logic [ILEN-1:0] instr_q;
  logic            is_compressed_q;
  logic            illegal_q;

  assign c      = instr_i[15:0];
  assign rd     = c[11:7];
  assign rs2    = c[6:2];
  assign rs1_p  = {2'b01, c[9:7]};
  // rd' of the C0 loads sits in the same bits as rs2'
  assign rs2_p  = {2'b01, c[4:2]};
  assign jal_rd = (op_i == C_JAL) ? REG_RA : REG_ZERO;

  ////////////////////////////////////////////////////////////////////////////
  // expansion
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    instr_d = '0;
    case (op_i)
      // addi rd', x2, nzuimm scaled by 4
      C_ADDI4SPN: begin
        instr_d = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                   REG_SP, 3'b000, rs2_p, OPCODE_OPIMM};
      end
      // lw rd', offset(rs1')
      C_LW: begin
        instr_d = {5'b0, c[5], c[12:10], c[6], 2'b00,
                   rs1_p, 3'b010, rs2_p, OPCODE_LOAD};
      end
      // sw rs2', offset(rs1'), offset split around the funct3
      C_SW: begin
        instr_d = {5'b0, c[5], c[12], rs2_p, rs1_p, 3'b010,
                   c[11:10], c[6], 2'b00, OPCODE_STORE};
      end

      // addi rd, rd, imm with sign-extended imm
      C_ADDI: begin
        instr_d = {{6{c[12]}}, c[12], c[6:2], rd, 3'b000, rd, OPCODE_OPIMM};
      end
      // jal x1 or jal x0, offset bits scattered over the word
      C_JAL, C_J: begin
        instr_d = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                   {9{c[12]}}, jal_rd, OPCODE_JAL};
      end
      // addi rd, x0, imm
      C_LI: begin
        instr_d = {{6{c[12]}}, c[12], c[6:2], REG_ZERO, 3'b000, rd, OPCODE_OPIMM};
      end
      // addi x2, x2, nzimm scaled by 16
      C_ADDI16SP: begin
        instr_d = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0,
                   REG_SP, 3'b000, REG_SP, OPCODE_OPIMM};
      end
      // lui rd, nzimm sign-extended from bit 17
      C_LUI: begin
        instr_d = {{15{c[12]}}, c[6:2], rd, OPCODE_LUI};
      end
      // srli and srai differ only in bit 30, taken from c[10]
      C_SRLI, C_SRAI: begin
        instr_d = {1'b0, c[10], 5'b0, c[6:2], rs1_p, 3'b101, rs1_p, OPCODE_OPIMM};
      end
      C_ANDI: begin
        instr_d = {{6{c[12]}}, c[12], c[6:2], rs1_p, 3'b111, rs1_p, OPCODE_OPIMM};
      end

      // register-register forms on the prime registers
      C_SUB: begin
        instr_d = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p, OPCODE_OP};
      end
      C_XOR: begin
        instr_d = {7'b0, rs2_p, rs1_p, 3'b100, rs1_p, OPCODE_OP};
      end
      C_OR: begin
        instr_d = {7'b0, rs2_p, rs1_p, 3'b110, rs1_p, OPCODE_OP};
      end
      C_AND: begin
        instr_d = {7'b0, rs2_p, rs1_p, 3'b111, rs1_p, OPCODE_OP};
      end
      // beq or bne against x0, c[13] picks the funct3
      C_BEQZ, C_BNEZ: begin
        instr_d = {{4{c[12]}}, c[6:5], c[2], REG_ZERO, rs1_p, 2'b00, c[13],
                   c[11:10], c[4:3], c[12], OPCODE_BRANCH};
      end

      // slli rd, rd, shamt
      C_SLLI: begin
        instr_d = {7'b0, c[6:2], rd, 3'b001, rd, OPCODE_OPIMM};
      end
      // lw rd, offset(x2)
      C_LWSP: begin
        instr_d = {4'b0, c[3:2], c[12], c[6:4], 2'b00,
                   REG_SP, 3'b010, rd, OPCODE_LOAD};
      end
      // jalr x0, 0(rs1)
      C_JR: begin
        instr_d = {12'b0, rd, 3'b000, REG_ZERO, OPCODE_JALR};
      end
      // add rd, x0, rs2
      C_MV: begin
        instr_d = {7'b0, rs2, REG_ZERO, 3'b000, rd, OPCODE_OP};
      end
      C_EBREAK: begin
        instr_d = EBREAK_WORD;
      end
      // jalr x1, 0(rs1)
      C_JALR: begin
        instr_d = {12'b0, rd, 3'b000, REG_RA, OPCODE_JALR};
      end
      // add rd, rd, rs2
      C_ADD: begin
        instr_d = {7'b0, rs2, rd, 3'b000, rd, OPCODE_OP};
      end
      // sw rs2, offset(x2)
      C_SWSP: begin
        instr_d = {4'b0, c[8:7], c[12], rs2, REG_SP, 3'b010,
                   c[11:9], 2'b00, OPCODE_STORE};
      end

      // 32-bit word goes through untouched
      C_FULL: begin
        instr_d = instr_i;
      end
      // illegal encodings leave the word at zero
      default: begin
        instr_d = '0;
      end
    endcase
  end

  // legality was settled in stage 1
  assign is_compressed_d = (op_i != C_FULL);
  assign illegal_d       = (op_i == C_ILLEGAL);

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      instr_q         <= instr_d;
      is_compressed_q <= is_compressed_d;
      illegal_q       <= illegal_d;
    end
  end

  assign valid_o         = valid_q;
  assign instr_o         = instr_q;
  assign is_compressed_o = is_compressed_q;
  assign illegal_instr_o = illegal_q;

endmodule

//--- hw/rvc_classify.sv
`timescale 1ns/1ps

module rvc_classify (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic [rvc_pkg::ILEN-1:0] instr_i,
  output logic                     valid_o,
  output logic [rvc_pkg::ILEN-1:0] instr_o,
  output rvc_pkg::c_op_e           op_o
);

  import rvc_pkg::*;

  // fields of the 16-bit encoding
  logic [1:0] quadrant;
  logic [2:0] funct3;
  reg_addr_t  rd;
  reg_addr_t  rs2;
  logic       nzimm_zero;

  c_op_e           op_d;
  c_op_e           op_q;
  logic            valid_q;
  logic [ILEN-1:0] instr_q;

  assign quadrant = instr_i[1:0];
  assign funct3   = instr_i[15:13];
  // rd and rs1 share bits 11:7 in the CI and CR formats
  assign rd       = instr_i[11:7];
  assign rs2      = instr_i[6:2];

  // six-bit immediate of c.addi16sp and c.lui
  assign nzimm_zero = ({instr_i[12], instr_i[6:2]} == 6'b0);

  ////////////////////////////////////////////////////////////////////////////
  // operation decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    op_d = C_ILLEGAL;
    case (quadrant)
      // quadrant 0
      2'b00: begin
        case (funct3)
          // zero nzuimm is the defined illegal instruction
          3'b000: op_d = (instr_i[12:5] == 8'b0) ? C_ILLEGAL : C_ADDI4SPN;
          3'b010: op_d = C_LW;
          3'b110: op_d = C_SW;
          // 100 reserved, fp loads and stores have no unit behind them
          default: op_d = C_ILLEGAL;
        endcase
      end

      // quadrant 1
      2'b01: begin
        case (funct3)
          // c.nop is a hint of c.addi
          3'b000: op_d = C_ADDI;
          3'b001: op_d = C_JAL;
          3'b010: op_d = C_LI;
          3'b011: begin
            if (nzimm_zero) begin
              op_d = C_ILLEGAL;
            end else if (rd == REG_SP) begin
              op_d = C_ADDI16SP;
            end else begin
              // rd zero is a hint and still expands
              op_d = C_LUI;
            end
          end
          3'b100: begin
            case (instr_i[11:10])
              // shamt[5] set is reserved on RV32
              2'b00: op_d = instr_i[12] ? C_ILLEGAL : C_SRLI;
              2'b01: op_d = instr_i[12] ? C_ILLEGAL : C_SRAI;
              2'b10: op_d = C_ANDI;
              default: begin
                case ({instr_i[12], instr_i[6:5]})
                  3'b000: op_d = C_SUB;
                  3'b001: op_d = C_XOR;
                  3'b010: op_d = C_OR;
                  3'b011: op_d = C_AND;
                  // c.subw, c.addw and the reserved pair
                  default: op_d = C_ILLEGAL;
                endcase
              end
            endcase
          end
          3'b101: op_d = C_J;
          3'b110: op_d = C_BEQZ;
          default: op_d = C_BNEZ;
        endcase
      end

      // quadrant 2
      2'b10: begin
        case (funct3)
          3'b000: op_d = instr_i[12] ? C_ILLEGAL : C_SLLI;
          // lwsp into x0 is reserved
          3'b010: op_d = (rd == REG_ZERO) ? C_ILLEGAL : C_LWSP;
          3'b100: begin
            if (!instr_i[12]) begin
              if (rs2 == REG_ZERO) begin
                op_d = (rd == REG_ZERO) ? C_ILLEGAL : C_JR;
              end else begin
                op_d = C_MV;
              end
            end else begin
              if (rs2 == REG_ZERO) begin
                op_d = (rd == REG_ZERO) ? C_EBREAK : C_JALR;
              end else begin
                op_d = C_ADD;
              end
            end
          end
          3'b110: op_d = C_SWSP;
          // stack-pointer fp forms
          default: op_d = C_ILLEGAL;
        endcase
      end

      // uncompressed word
      default: op_d = C_FULL;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // word and code only move with a valid item
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      instr_q <= instr_i;
      op_q    <= op_d;
    end
  end

  assign valid_o = valid_q;
  assign instr_o = instr_q;
  assign op_o    = op_q;

endmodule

//--- hw/rvc_pkg.sv
package rvc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and register indices
  ////////////////////////////////////////////////////////////////////////////

  // base instruction width, RV32 only
  localparam int unsigned ILEN = 32;

  // architectural register index
  typedef logic [4:0] reg_addr_t;

  // fixed registers named by the compressed forms
  localparam reg_addr_t REG_ZERO = 5'd0;
  localparam reg_addr_t REG_RA   = 5'd1;
  localparam reg_addr_t REG_SP   = 5'd2;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  // major opcodes produced by the expansion
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OPIMM  = 7'h13,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f,
    OPCODE_SYSTEM = 7'h73
  } opcode_e;

  // compressed operation picked by stage 1
  // hints share the code of their base form
  typedef enum logic [4:0] {
    // quadrant 0
    C_ADDI4SPN, C_LW, C_SW,
    // quadrant 1
    C_ADDI, C_JAL, C_J, C_LI, C_ADDI16SP, C_LUI,
    C_SRLI, C_SRAI, C_ANDI, C_SUB, C_XOR, C_OR, C_AND,
    C_BEQZ, C_BNEZ,
    // quadrant 2
    C_SLLI, C_LWSP, C_JR, C_MV, C_EBREAK, C_JALR, C_ADD, C_SWSP,
    // reserved or illegal 16-bit encoding
    C_ILLEGAL,
    // 32-bit word, bits 1:0 equal 11
    C_FULL
  } c_op_e;

  // ebreak, funct12 001 with zero registers on the system opcode
  localparam logic [ILEN-1:0] EBREAK_WORD =
    {12'h001, REG_ZERO, 3'b000, REG_ZERO, OPCODE_SYSTEM};

endpackage
